// ==== hdl/sccb_pkg.sv ====
package sccb_pkg;

	////////////////////////////////////////
	// Widths

	// Link layer word, four bytes
	localparam int LL_WIDTH   = 32;

	// APB requester bus
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	////////////////////////////////////////
	// Frame type codes, low byte of the header word

	// K27.7, APB write request
	localparam logic [7:0] FRAME_APB_WRITE  = 8'hfb;
	// K28.0, APB read request
	localparam logic [7:0] FRAME_APB_READ   = 8'h1c;
	// K29.7, completion carrying read data
	localparam logic [7:0] FRAME_COMP_DATA  = 8'hfd;
	// K23.7, completion with status only
	localparam logic [7:0] FRAME_COMP_EMPTY = 8'hf7;

	////////////////////////////////////////
	// Link word views

	// First word of a frame
	// Listed high byte first, so frame_type sits in bits 7:0
	typedef struct packed {
		logic [7:0] hi_b3;
		logic [7:0] hi_b2;
		logic [7:0] seq;
		logic [7:0] frame_type;
	} ll_hdr_t;

	// Every later word of a frame
	typedef struct packed {
		logic [7:0] hi_b3;
		logic [7:0] hi_b2;
		logic [7:0] lo_b1;
		logic [7:0] lo_b0;
	} ll_body_t;

	// Same 32 bits, decoded by position in the frame
	typedef union packed {
		ll_hdr_t  hdr;
		ll_body_t body;
	} ll_word_u;

	// Which word the controller is presenting this cycle
	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_REQ_WR_HDR,
		LOAD_REQ_RD_HDR,
		LOAD_REQ_W1,
		LOAD_REQ_W2,
		LOAD_COMP_EMPTY,
		LOAD_COMP_DATA_HDR,
		LOAD_COMP_W1
	} load_sel_e;

endpackage

// ==== hdl/sccb_frame_ctrl.sv ====
`timescale 1ns/1ps

module sccb_frame_ctrl (
	input  logic                rx_clk,
	input  logic                arst_n,
	input  sccb_pkg::ll_word_u  ll_word,
	input  logic                ll_start,
	input  logic                ll_valid,
	input  logic                ll_commit,
	input  logic                ll_drop,
	input  logic                ll_link_up,
	output sccb_pkg::load_sel_e load_sel,
	output logic                sel_set,
	output logic                enable_set,
	output logic                sel_abort
);

	import sccb_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ_W1,
		ST_REQ_W2,
		ST_SEL_WAIT,
		ST_COMP_W1
	} state_e;

	state_e state;
	state_e state_nxt;

	// Direction of the request in flight, picks the word count
	logic req_wr;

	// Body word present and not abandoned
	logic word_ok;

	assign word_ok = ll_valid && !ll_drop;

	////////////////////////////////////////
	// Next state and word steering

	always_comb begin
		state_nxt  = state;
		load_sel   = LOAD_NONE;
		sel_set    = 1'b0;
		enable_set = 1'b0;
		sel_abort  = 1'b0;

		case (state)
			// Wait for a header, frame type in the low byte
			ST_IDLE: begin
				if (ll_start && !ll_drop) begin
					case (ll_word.hdr.frame_type)
						FRAME_APB_WRITE: begin
							load_sel  = LOAD_REQ_WR_HDR;
							state_nxt = ST_REQ_W1;
						end
						FRAME_APB_READ: begin
							load_sel  = LOAD_REQ_RD_HDR;
							state_nxt = ST_REQ_W1;
						end
						// Single word frame, nothing more to wait for
						FRAME_COMP_EMPTY: load_sel = LOAD_COMP_EMPTY;
						FRAME_COMP_DATA: begin
							load_sel  = LOAD_COMP_DATA_HDR;
							state_nxt = ST_COMP_W1;
						end
						// Unknown types are ignored
						default: ;
					endcase
				end
			end

			// Address low half, plus write data high half
			ST_REQ_W1: begin
				if (word_ok) begin
					load_sel = LOAD_REQ_W1;
					if (req_wr) begin
						state_nxt = ST_REQ_W2;
					end else begin
						// Read ends here
						sel_set   = 1'b1;
						state_nxt = ST_SEL_WAIT;
					end
				end else begin
					state_nxt = ST_IDLE;
				end
			end

			// Write data low half
			ST_REQ_W2: begin
				if (word_ok) begin
					load_sel  = LOAD_REQ_W2;
					sel_set   = 1'b1;
					state_nxt = ST_SEL_WAIT;
				end else begin
					state_nxt = ST_IDLE;
				end
			end

			// psel is up, commit releases the access phase
			ST_SEL_WAIT: begin
				if (ll_drop) begin
					sel_abort = 1'b1;
					state_nxt = ST_IDLE;
				end else if (ll_commit) begin
					enable_set = 1'b1;
					state_nxt  = ST_IDLE;
				end
			end

			// Read data low half, back to idle either way
			ST_COMP_W1: begin
				if (word_ok)
					load_sel = LOAD_COMP_W1;
				state_nxt = ST_IDLE;
			end

			default: state_nxt = ST_IDLE;
		endcase

		// Link down overrides everything
		if (!ll_link_up) begin
			state_nxt  = ST_IDLE;
			load_sel   = LOAD_NONE;
			sel_set    = 1'b0;
			enable_set = 1'b0;
			sel_abort  = (state == ST_SEL_WAIT);
		end
	end

	////////////////////////////////////////
	// State registers

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= ST_IDLE;
			req_wr <= 1'b0;
		end else begin
			state <= state_nxt;
			// Latch direction with the header
			if (load_sel == LOAD_REQ_WR_HDR)
				req_wr <= 1'b1;
			else if (load_sel == LOAD_REQ_RD_HDR)
				req_wr <= 1'b0;
		end
	end

endmodule

// ==== hdl/sccb_req_assembler.sv ====
`timescale 1ns/1ps

module sccb_req_assembler (
	input  logic                          rx_clk,
	input  logic                          arst_n,
	input  sccb_pkg::ll_word_u            ll_word,
	input  sccb_pkg::load_sel_e           load_sel,
	output logic [sccb_pkg::ADDR_WIDTH-1:0] paddr,
	output logic [sccb_pkg::DATA_WIDTH-1:0] pwdata,
	output logic                          pwrite
);

	import sccb_pkg::*;

	////////////////////////////////////////
	// Address and direction

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			paddr  <= '0;
			pwrite <= 1'b0;
		end else begin
			case (load_sel)
				// Header view, seq byte is skipped
				LOAD_REQ_WR_HDR: begin
					paddr[31:16] <= {ll_word.hdr.hi_b2, ll_word.hdr.hi_b3};
					pwrite       <= 1'b1;
				end
				LOAD_REQ_RD_HDR: begin
					paddr[31:16] <= {ll_word.hdr.hi_b2, ll_word.hdr.hi_b3};
					pwrite       <= 1'b0;
				end
				// Body view, low bytes carry address 15:0
				LOAD_REQ_W1: paddr[15:0] <= {ll_word.body.lo_b0, ll_word.body.lo_b1};
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Write data

	// Loaded on reads too, the value is then never used
	always_ff @(posedge rx_clk) begin
		case (load_sel)
			LOAD_REQ_W1: pwdata[31:16] <= {ll_word.body.hi_b2, ll_word.body.hi_b3};
			LOAD_REQ_W2: pwdata[15:0]  <= {ll_word.body.lo_b0, ll_word.body.lo_b1};
			default: ;
		endcase
	end

endmodule

// ==== hdl/sccb_apb_requester.sv ====
`timescale 1ns/1ps

module sccb_apb_requester (
	input  logic                          rx_clk,
	input  logic                          arst_n,
	input  logic                          sel_set,
	input  logic                          enable_set,
	input  logic                          sel_abort,
	input  logic                          pwrite,
	input  logic                          pready,
	input  logic                          pslverr,
	input  logic [sccb_pkg::DATA_WIDTH-1:0] prdata,
	output logic                          psel,
	output logic                          penable,
	output logic                          comp_valid,
	output logic                          comp_has_data,
	output logic                          comp_success,
	output logic [sccb_pkg::DATA_WIDTH-1:0] comp_data
);

	// Last cycle of the access phase
	logic xfer_done;

	assign xfer_done = psel && penable && pready;

	////////////////////////////////////////
	// Bus control and completion strobe

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			psel       <= 1'b0;
			penable    <= 1'b0;
			comp_valid <= 1'b0;
		end else begin
			// One cycle pulse after the transfer ends
			comp_valid <= xfer_done;

			if (xfer_done) begin
				psel    <= 1'b0;
				penable <= 1'b0;
			end else if (sel_abort) begin
				// Frame dropped before commit, never reaches access phase
				psel    <= 1'b0;
				penable <= 1'b0;
			end else begin
				if (sel_set)
					psel <= 1'b1;
				// Access phase only from a live setup phase
				if (enable_set && psel)
					penable <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Completion fields, held until the next strobe

	always_ff @(posedge rx_clk) begin
		if (xfer_done) begin
			// Data goes back only for a successful read
			comp_has_data <= !pwrite && !pslverr;
			comp_success  <= !pslverr;
			comp_data     <= prdata;
		end
	end

endmodule

// ==== hdl/sccb_ack_capture.sv ====
`timescale 1ns/1ps

module sccb_ack_capture (
	input  logic                          rx_clk,
	input  logic                          arst_n,
	input  sccb_pkg::ll_word_u            ll_word,
	input  sccb_pkg::load_sel_e           load_sel,
	input  logic                          ll_commit,
	input  logic                          ll_drop,
	output logic                          ack_valid,
	output logic                          ack_error,
	output logic [sccb_pkg::DATA_WIDTH-1:0] ack_data
);

	import sccb_pkg::*;

	// Completion fully received, waiting on commit
	logic pending;

	////////////////////////////////////////
	// Pending flag and strobe

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			pending   <= 1'b0;
			ack_valid <= 1'b0;
		end else begin
			ack_valid <= pending && ll_commit && !ll_drop;
			// Commit or drop both close the frame
			if (ll_commit || ll_drop)
				pending <= 1'b0;
			if (load_sel == LOAD_COMP_EMPTY || load_sel == LOAD_COMP_W1)
				pending <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Completion contents

	always_ff @(posedge rx_clk) begin
		case (load_sel)
			// Status in bit 16, set means success
			LOAD_COMP_EMPTY: begin
				ack_data  <= '0;
				ack_error <= !ll_word.hdr.hi_b2[0];
			end
			LOAD_COMP_DATA_HDR: ack_data[31:16] <= {ll_word.hdr.hi_b2, ll_word.hdr.hi_b3};
			LOAD_COMP_W1: begin
				ack_data[15:0] <= {ll_word.body.lo_b0, ll_word.body.lo_b1};
				ack_error      <= 1'b0;
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/sccb_apb_rx_bridge.sv ====
`timescale 1ns/1ps

module sccb_apb_rx_bridge (
	input  logic                          rx_clk,
	input  logic                          arst_n,

	// Decoded link layer words
	input  logic [sccb_pkg::LL_WIDTH-1:0]   ll_word,
	input  logic                          ll_start,
	input  logic                          ll_valid,
	input  logic                          ll_commit,
	input  logic                          ll_drop,
	input  logic                          ll_link_up,

	// APB requester
	output logic [sccb_pkg::ADDR_WIDTH-1:0] paddr,
	output logic [sccb_pkg::DATA_WIDTH-1:0] pwdata,
	output logic                          pwrite,
	output logic                          psel,
	output logic                          penable,
	input  logic                          pready,
	input  logic                          pslverr,
	input  logic [sccb_pkg::DATA_WIDTH-1:0] prdata,

	// Completion for the transmit side
	output logic                          comp_valid,
	output logic                          comp_has_data,
	output logic                          comp_success,
	output logic [sccb_pkg::DATA_WIDTH-1:0] comp_data,

	// Acknowledge of a far side completion
	output logic                          ack_valid,
	output logic                          ack_error,
	output logic [sccb_pkg::DATA_WIDTH-1:0] ack_data
);

	import sccb_pkg::*;

	load_sel_e load_sel;
	logic      sel_set;
	logic      enable_set;
	logic      sel_abort;

	////////////////////////////////////////
	// Frame sequencing

	sccb_frame_ctrl u_frame_ctrl (
		.rx_clk     (rx_clk),
		.arst_n     (arst_n),
		.ll_word    (ll_word),
		.ll_start   (ll_start),
		.ll_valid   (ll_valid),
		.ll_commit  (ll_commit),
		.ll_drop    (ll_drop),
		.ll_link_up (ll_link_up),
		.load_sel   (load_sel),
		.sel_set    (sel_set),
		.enable_set (enable_set),
		.sel_abort  (sel_abort)
	);

	////////////////////////////////////////
	// Datapath

	sccb_req_assembler u_req_assembler (
		.rx_clk   (rx_clk),
		.arst_n   (arst_n),
		.ll_word  (ll_word),
		.load_sel (load_sel),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pwrite   (pwrite)
	);

	sccb_apb_requester u_apb_requester (
		.rx_clk        (rx_clk),
		.arst_n        (arst_n),
		.sel_set       (sel_set),
		.enable_set    (enable_set),
		.sel_abort     (sel_abort),
		.pwrite        (pwrite),
		.pready        (pready),
		.pslverr       (pslverr),
		.prdata        (prdata),
		.psel          (psel),
		.penable       (penable),
		.comp_valid    (comp_valid),
		.comp_has_data (comp_has_data),
		.comp_success  (comp_success),
		.comp_data     (comp_data)
	);

	sccb_ack_capture u_ack_capture (
		.rx_clk    (rx_clk),
		.arst_n    (arst_n),
		.ll_word   (ll_word),
		.load_sel  (load_sel),
		.ll_commit (ll_commit),
		.ll_drop   (ll_drop),
		.ack_valid (ack_valid),
		.ack_error (ack_error),
		.ack_data  (ack_data)
	);

endmodule

// ==== dv/sccb_apb_rx_tb.sv ====
`timescale 1ns/1ps

module sccb_apb_rx_tb;

	import sccb_pkg::*;

	// Ways a request frame can be abandoned
	typedef enum int {
		FAULT_NONE,
		FAULT_DROP,
		FAULT_NO_VALID,
		FAULT_LINK
	} fault_e;

	logic        rx_clk;
	logic        arst_n;
	logic [31:0] ll_word;
	logic        ll_start;
	logic        ll_valid;
	logic        ll_commit;
	logic        ll_drop;
	logic        ll_link_up;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic        pwrite;
	logic        psel;
	logic        penable;
	logic        pready;
	logic        pslverr;
	logic [31:0] prdata;
	logic        comp_valid;
	logic        comp_has_data;
	logic        comp_success;
	logic [31:0] comp_data;
	logic        ack_valid;
	logic        ack_error;
	logic [31:0] ack_data;

	// Expected requests and acknowledges, oldest first
	logic        exp_write[$];
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic        exp_ack_err[$];
	logic [31:0] exp_ack_data[$];

	// Last APB transfer as seen by the completer
	logic [31:0] apb_addr;
	logic [31:0] apb_wdata;
	logic        apb_write;
	int          xfer_cnt;

	// Strobe counters kept by the checker
	int          comp_cnt;
	int          ack_cnt;
	int          pen_cnt;
	logic        pen_prev;

	// Error counts, one per process
	int          err_value;
	int          err_chk;
	int          err_main;

	logic [31:0] rng_stim;
	logic [31:0] rng_lat;
	logic [1:0]  wait_left;
	logic [7:0]  seq_num;
	string       test_name;

	sccb_apb_rx_bridge UUT (
		.rx_clk        (rx_clk),
		.arst_n        (arst_n),
		.ll_word       (ll_word),
		.ll_start      (ll_start),
		.ll_valid      (ll_valid),
		.ll_commit     (ll_commit),
		.ll_drop       (ll_drop),
		.ll_link_up    (ll_link_up),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.pwrite        (pwrite),
		.psel          (psel),
		.penable       (penable),
		.pready        (pready),
		.pslverr       (pslverr),
		.prdata        (prdata),
		.comp_valid    (comp_valid),
		.comp_has_data (comp_has_data),
		.comp_success  (comp_success),
		.comp_data     (comp_data),
		.ack_valid     (ack_valid),
		.ack_error     (ack_error),
		.ack_data      (ack_data)
	);

	initial begin
		rx_clk = 1'b0;
		forever #2 rx_clk = ~rx_clk;
	end

	////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Completer read data, every address bit matters
	function automatic logic [31:0] read_pattern(input logic [31:0] a);
		return {a[15:0] ^ 16'hc3a5, ~a[31:16]};
	endfunction

	// {comp_has_data, comp_success, comp_data}, odd address means slave error
	function automatic logic [33:0] expect_completion(input logic w, input logic [31:0] a);
		logic err;
		err = a[0];
		return {!w && !err, !err, read_pattern(a)};
	endfunction

	////////////////////////////////////////
	// APB completer

	initial begin
		pready    = 1'b0;
		pslverr   = 1'b0;
		prdata    = 32'h0;
		wait_left = 2'd0;
		rng_lat   = xorshift32(32'hf60ebc9b);
		xfer_cnt  = 0;
		forever begin
			@(posedge rx_clk);
			#1;
			if (pready) begin
				// Single response cycle
				pready  = 1'b0;
				pslverr = 1'b0;
				prdata  = 32'h0;
			end else if (psel && penable) begin
				if (wait_left == 2'd0) begin
					pready    = 1'b1;
					pslverr   = paddr[0];
					prdata    = read_pattern(paddr);
					apb_addr  = paddr;
					apb_wdata = pwdata;
					apb_write = pwrite;
					xfer_cnt  = xfer_cnt + 1;
				end else begin
					wait_left = wait_left - 2'd1;
				end
			end else begin
				// Fresh latency of 0 to 3 cycles for the next access phase
				rng_lat   = xorshift32(rng_lat);
				wait_left = rng_lat[1:0];
			end
		end
	end

	////////////////////////////////////////
	// Checker

	task automatic report_mismatch(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Fail %s: %s expected %h actual %h", test_name, field, exp, act);
		err_value = err_value + 1;
	endtask

	task automatic check_completion();
		logic [33:0] exp;
		logic        w;
		logic [31:0] a;
		logic [31:0] d;
		comp_cnt = comp_cnt + 1;
		if (exp_addr.size() == 0) begin
			$display("%s: completion strobe with no request outstanding", test_name);
			err_chk = err_chk + 1;
		end else begin
			w   = exp_write.pop_front();
			a   = exp_addr.pop_front();
			d   = exp_data.pop_front();
			exp = expect_completion(w, a);
			// One APB transfer per completion
			if (xfer_cnt != comp_cnt) begin
				$display("%s: %0d APB transfers for %0d completions", test_name,
					xfer_cnt, comp_cnt);
				err_chk = err_chk + 1;
			end
			if (apb_addr !== a)
				report_mismatch("paddr", a, apb_addr);
			if (apb_write !== w)
				report_mismatch("pwrite", 32'(w), 32'(apb_write));
			if (w && apb_wdata !== d)
				report_mismatch("pwdata", d, apb_wdata);
			if (comp_has_data !== exp[33])
				report_mismatch("comp_has_data", 32'(exp[33]), 32'(comp_has_data));
			if (comp_success !== exp[32])
				report_mismatch("comp_success", 32'(exp[32]), 32'(comp_success));
			if (comp_data !== exp[31:0])
				report_mismatch("comp_data", exp[31:0], comp_data);
		end
	endtask

	task automatic check_ack();
		logic        e;
		logic [31:0] d;
		ack_cnt = ack_cnt + 1;
		if (exp_ack_err.size() == 0) begin
			$display("%s: ack_valid with no completion frame committed", test_name);
			err_chk = err_chk + 1;
		end else begin
			e = exp_ack_err.pop_front();
			d = exp_ack_data.pop_front();
			if (ack_error !== e)
				report_mismatch("ack_error", 32'(e), 32'(ack_error));
			if (ack_data !== d)
				report_mismatch("ack_data", d, ack_data);
		end
	endtask

	// Samples mid cycle, clear of the stimulus edge
	initial begin
		comp_cnt  = 0;
		ack_cnt   = 0;
		pen_cnt   = 0;
		pen_prev  = 1'b0;
		err_value = 0;
		err_chk   = 0;
		forever begin
			@(posedge rx_clk);
			#2;
			if (penable === 1'b1 && !pen_prev)
				pen_cnt = pen_cnt + 1;
			pen_prev = (penable === 1'b1);
			if (comp_valid === 1'b1)
				check_completion();
			if (ack_valid === 1'b1)
				check_ack();
		end
	end

	////////////////////////////////////////
	// Frame stimulus

	// One link cycle, driven just after the edge
	task automatic drive_cycle(input logic [31:0] w, input logic start, input logic valid,
		input logic commit, input logic drop, input logic link);
		@(posedge rx_clk);
		#1;
		ll_word    = w;
		ll_start   = start;
		ll_valid   = valid;
		ll_commit  = commit;
		ll_drop    = drop;
		ll_link_up = link;
	endtask

	task automatic wait_strobe(input logic want_ack, input int target);
		int    n;
		string what;
		n = 0;
		if (want_ack)
			what = "ack_valid";
		else
			what = "comp_valid";
		while ((want_ack ? ack_cnt : comp_cnt) < target && n < 40) begin
			@(posedge rx_clk);
			#1;
			n = n + 1;
		end
		if ((want_ack ? ack_cnt : comp_cnt) < target) begin
			$display("Timeout in %s: no %s strobe within 40 cycles", test_name, what);
			err_main = err_main + 1;
		end
	endtask

	task automatic send_request(input logic w, input logic [31:0] a, input logic [31:0] d,
		input fault_e fault);
		logic [31:0] hdr;
		logic [31:0] w1;
		logic [31:0] w2;
		seq_num = seq_num + 8'd1;
		// Header bytes 3 and 2 carry address 23:16 and 31:24
		hdr = {a[23:16], a[31:24], seq_num, w ? FRAME_APB_WRITE : FRAME_APB_READ};
		w1  = {d[23:16], d[31:24], a[7:0], a[15:8]};
		w2  = {16'h0, d[7:0], d[15:8]};
		if (fault == FAULT_NONE) begin
			exp_write.push_back(w);
			exp_addr.push_back(a);
			exp_data.push_back(d);
		end
		drive_cycle(hdr, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
		drive_cycle(w1, 1'b0, fault != FAULT_NO_VALID, 1'b0, 1'b0, 1'b1);
		if (w)
			drive_cycle(w2, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
		// Gap before commit, where faults land
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b0, fault == FAULT_DROP, fault != FAULT_LINK);
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic run_request(input logic w, input logic [31:0] a, input logic [31:0] d);
		int target;
		target = comp_cnt + 1;
		send_request(w, a, d, FAULT_NONE);
		wait_strobe(1'b0, target);
	endtask

	task automatic run_abandoned(input logic w, input fault_e fault);
		int          pen_before;
		int          comp_before;
		logic [31:0] a;
		logic [31:0] d;
		rng_stim    = xorshift32(rng_stim);
		a           = {rng_stim[31:1], 1'b0};
		rng_stim    = xorshift32(rng_stim);
		d           = rng_stim;
		pen_before  = pen_cnt;
		comp_before = comp_cnt;
		send_request(w, a, d, fault);
		// Window longer than the slowest completer
		repeat (12) begin
			@(posedge rx_clk);
		end
		if (pen_cnt != pen_before) begin
			$display("%s: access phase started for an abandoned frame", test_name);
			err_main = err_main + 1;
		end
		if (comp_cnt != comp_before) begin
			$display("%s: completion strobe for an abandoned frame", test_name);
			err_main = err_main + 1;
		end
		if (psel !== 1'b0) begin
			$display("%s: psel still high after an abandoned frame", test_name);
			err_main = err_main + 1;
		end
		// Next clean frame must go through
		run_request(w, a, d);
	endtask

	task automatic send_completion(input logic has_data, input logic status,
		input logic [31:0] v, input logic drop);
		logic [31:0] hdr;
		int          target;
		seq_num  = seq_num + 8'd1;
		rng_stim = xorshift32(rng_stim);
		target   = ack_cnt + 1;
		if (has_data)
			hdr = {v[23:16], v[31:24], seq_num, FRAME_COMP_DATA};
		else
			hdr = {rng_stim[15:8], rng_stim[7:1], status, seq_num, FRAME_COMP_EMPTY};
		if (!drop) begin
			exp_ack_err.push_back(has_data ? 1'b0 : !status);
			exp_ack_data.push_back(has_data ? v : 32'h0);
		end
		drive_cycle(hdr, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
		if (has_data)
			drive_cycle({rng_stim[31:16], v[7:0], v[15:8]}, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b0, drop, 1'b1);
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		drive_cycle(32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		if (drop) begin
			repeat (6) begin
				@(posedge rx_clk);
			end
			if (ack_cnt != target - 1) begin
				$display("%s: ack_valid for a dropped completion frame", test_name);
				err_main = err_main + 1;
			end
		end else begin
			wait_strobe(1'b1, target);
		end
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		int          i;
		logic [31:0] a;
		logic [31:0] d;
		arst_n     = 1'b0;
		ll_word    = 32'h0;
		ll_start   = 1'b0;
		ll_valid   = 1'b0;
		ll_commit  = 1'b0;
		ll_drop    = 1'b0;
		ll_link_up = 1'b1;
		rng_stim   = 32'hf60ebc9b;
		seq_num    = 8'h0;
		err_main   = 0;
		test_name  = "reset";

		repeat (10) begin
			@(posedge rx_clk);
		end
		#1;
		arst_n = 1'b1;
		if (psel !== 1'b0 || penable !== 1'b0 || comp_valid !== 1'b0 || ack_valid !== 1'b0) begin
			$display("reset: bus or strobe outputs not low after reset");
			err_main = err_main + 1;
		end

		test_name = "write";
		for (i = 0; i < 4; i++) begin
			rng_stim = xorshift32(rng_stim);
			a        = {rng_stim[31:1], 1'b0};
			rng_stim = xorshift32(rng_stim);
			d        = rng_stim;
			run_request(1'b1, a, d);
		end

		test_name = "read";
		for (i = 0; i < 4; i++) begin
			rng_stim = xorshift32(rng_stim);
			a        = {rng_stim[31:1], 1'b0};
			run_request(1'b0, a, 32'h0);
		end

		// Address bit 0 set makes the completer answer with pslverr
		test_name = "slave_error";
		rng_stim = xorshift32(rng_stim);
		run_request(1'b1, {rng_stim[31:1], 1'b1}, ~rng_stim);
		rng_stim = xorshift32(rng_stim);
		run_request(1'b0, {rng_stim[31:1], 1'b1}, 32'h0);

		test_name = "abandon";
		for (i = 0; i < 2; i++) begin
			run_abandoned(i == 0, FAULT_DROP);
			run_abandoned(i == 0, FAULT_NO_VALID);
			run_abandoned(i == 0, FAULT_LINK);
		end

		test_name = "comp_empty";
		send_completion(1'b0, 1'b1, 32'h0, 1'b0);
		send_completion(1'b0, 1'b0, 32'h0, 1'b0);

		test_name = "comp_data";
		for (i = 0; i < 3; i++) begin
			rng_stim = xorshift32(rng_stim);
			send_completion(1'b1, 1'b0, rng_stim, 1'b0);
		end

		test_name = "comp_drop";
		send_completion(1'b0, 1'b1, 32'h0, 1'b1);
		rng_stim = xorshift32(rng_stim);
		send_completion(1'b1, 1'b0, rng_stim, 1'b1);

		// Mixed direction and error
		test_name = "random";
		for (i = 0; i < 8; i++) begin
			rng_stim = xorshift32(rng_stim);
			a        = rng_stim;
			rng_stim = xorshift32(rng_stim);
			run_request(rng_stim[7], a, rng_stim);
		end

		if (exp_addr.size() != 0 || exp_ack_err.size() != 0) begin
			$display("end: %0d requests and %0d acks never completed", exp_addr.size(),
				exp_ack_err.size());
			err_main = err_main + 1;
		end

		$display("Errors: %0d value, %0d protocol, %0d sequence (%0d completions, %0d acks)",
			err_value, err_chk, err_main, comp_cnt, ack_cnt);
		if (err_value + err_chk + err_main == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/sccb_pkg.sv
hdl/sccb_frame_ctrl.sv
hdl/sccb_req_assembler.sv
hdl/sccb_apb_requester.sv
hdl/sccb_ack_capture.sv
hdl/sccb_apb_rx_bridge.sv
dv/sccb_apb_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the receive bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module sccb_apb_rx_tb -o sccb_apb_rx_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sccb_apb_rx_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0
